//--- retrosoc_settings.svh
// memory map and register offsets; offsets are byte addresses compared over the whole 24-bit field
`ifndef RETROSOC_SETTINGS_SVH
`define RETROSOC_SETTINGS_SVH

// region codes, upper address byte
`define RETRO_REGION_SRAM  8'h00
`define RETRO_REGION_GPIO  8'h03
`define RETRO_REGION_TIMER 8'h04

// sram word address width, 256 words
`define RETRO_SRAM_AW 8

// read data for an unmapped region
`define RETRO_BUS_ERR_WORD 32'hDEAD_BEEF

`define RETRO_GPIO_W 8

// gpio register offsets
`define GPIO_OUT      24'h00_0000
`define GPIO_IN       24'h00_0004
`define GPIO_OEN      24'h00_0008
`define GPIO_PUN      24'h00_000C
`define GPIO_PDN      24'h00_0010
`define GPIO_IRQ_EN   24'h00_0014
`define GPIO_IRQ_STAT 24'h00_0018

// timer register offsets
`define TMR_CNT  24'h00_0000
`define TMR_CMP  24'h00_0004
`define TMR_CTRL 24'h00_0008
`define TMR_STAT 24'h00_000C

`endif

//--- retrosoc_pkg.sv
// address types only; any region code outside the settings header is treated as unmapped
package retrosoc_pkg;

  // upper byte picks the slave, the rest is local to it
  typedef struct packed {
    logic [7:0]  region;
    logic [23:0] offset;
  } nmi_addr_s;

  // one bus address, seen as a raw word or as region plus offset
  typedef union packed {
    logic [31:0] raw;
    nmi_addr_s   fld;
  } nmi_addr_u;

endpackage

//--- nmi_bus.sv
// single master, three slaves; master must hold addr until ready, unmapped reads get the error word
`timescale 1ns/10ps
`include "retrosoc_settings.svh"

module nmi_bus (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    mem_valid_i,
  input  retrosoc_pkg::nmi_addr_u mem_addr_i,
  input  logic [31:0]             mem_wdata_i,
  input  logic [3:0]              mem_wstrb_i,
  output logic                    mem_ready_o,
  output logic [31:0]             mem_rdata_o,
  output logic                    sram_valid_o,
  input  logic                    sram_ready_i,
  input  logic [31:0]             sram_rdata_i,
  output logic                    gpio_valid_o,
  input  logic                    gpio_ready_i,
  input  logic [31:0]             gpio_rdata_i,
  output logic                    tmr_valid_o,
  input  logic                    tmr_ready_i,
  input  logic [31:0]             tmr_rdata_i,
  output retrosoc_pkg::nmi_addr_u slv_addr_o,
  output logic [31:0]             slv_wdata_o,
  output logic [3:0]              slv_wstrb_o,
  output logic                    bus_err_o
);

  logic sel_sram;
  logic sel_gpio;
  logic sel_tmr;
  logic sel_none;
  logic err_ready_q;

  // region decode
  assign sel_sram = (mem_addr_i.fld.region == `RETRO_REGION_SRAM);
  assign sel_gpio = (mem_addr_i.fld.region == `RETRO_REGION_GPIO);
  assign sel_tmr  = (mem_addr_i.fld.region == `RETRO_REGION_TIMER);
  assign sel_none = ~(sel_sram | sel_gpio | sel_tmr);

  assign sram_valid_o = mem_valid_i & sel_sram;
  assign gpio_valid_o = mem_valid_i & sel_gpio;
  assign tmr_valid_o  = mem_valid_i & sel_tmr;

  assign slv_addr_o  = mem_addr_i;
  assign slv_wdata_o = mem_wdata_i;
  assign slv_wstrb_o = mem_wstrb_i;

  // unmapped access answered here, same latency as a slave
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_ready_q <= 1'b0;
    end else begin
      err_ready_q <= mem_valid_i & sel_none & ~err_ready_q;
    end
  end

  assign bus_err_o = err_ready_q;

  // return path follows the region still held on the address
  always_comb begin
    mem_ready_o = err_ready_q;
    mem_rdata_o = `RETRO_BUS_ERR_WORD;
    if (sel_sram) begin
      mem_ready_o = sram_ready_i;
      mem_rdata_o = sram_rdata_i;
    end else if (sel_gpio) begin
      mem_ready_o = gpio_ready_i;
      mem_rdata_o = gpio_rdata_i;
    end else if (sel_tmr) begin
      mem_ready_o = tmr_ready_i;
      mem_rdata_o = tmr_rdata_i;
    end
  end

endmodule

//--- nmi_sram.sv
// 256-word ram, contents undefined after power-up; a write returns the old word on rdata
`timescale 1ns/10ps
`include "retrosoc_settings.svh"

module nmi_sram (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  retrosoc_pkg::nmi_addr_u addr_i,
  input  logic [31:0]             wdata_i,
  input  logic [3:0]              wstrb_i,
  output logic                    ready_o,
  output logic [31:0]             rdata_o
);

  logic [31:0]              mem [0:(1<<`RETRO_SRAM_AW)-1];
  logic [`RETRO_SRAM_AW-1:0] word_idx;
  logic                     ready_q;
  logic                     acc;

  // word index sits just above the byte lane bits
  assign word_idx = addr_i.raw[`RETRO_SRAM_AW+1:2];
  assign acc      = valid_i & ~ready_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_o <= mem[word_idx];
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign ready_o = ready_q;

endmodule

//--- natv_gpio.sv
// any nonzero strobe writes the full word; inputs are async and pass a two-flop synchronizer
`timescale 1ns/10ps
`include "retrosoc_settings.svh"

module natv_gpio (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     valid_i,
  input  retrosoc_pkg::nmi_addr_u  addr_i,
  input  logic [31:0]              wdata_i,
  input  logic [3:0]               wstrb_i,
  output logic                     ready_o,
  output logic [31:0]              rdata_o,
  input  logic [`RETRO_GPIO_W-1:0] gpio_in_i,
  output logic [`RETRO_GPIO_W-1:0] gpio_out_o,
  output logic [`RETRO_GPIO_W-1:0] gpio_oen_o,
  output logic [`RETRO_GPIO_W-1:0] gpio_pun_o,
  output logic [`RETRO_GPIO_W-1:0] gpio_pdn_o,
  output logic                     irq_o
);

  logic [`RETRO_GPIO_W-1:0] out_q;
  logic [`RETRO_GPIO_W-1:0] oen_q;
  logic [`RETRO_GPIO_W-1:0] pun_q;
  logic [`RETRO_GPIO_W-1:0] pdn_q;
  logic [`RETRO_GPIO_W-1:0] irq_en_q;
  logic [`RETRO_GPIO_W-1:0] irq_stat_q;
  logic [`RETRO_GPIO_W-1:0] sync1_q;
  logic [`RETRO_GPIO_W-1:0] sync2_q;
  logic [`RETRO_GPIO_W-1:0] prev_q;
  logic [`RETRO_GPIO_W-1:0] rise;
  logic [`RETRO_GPIO_W-1:0] stat_clr;
  logic [`RETRO_GPIO_W-1:0] wr_val;
  logic [`RETRO_GPIO_W-1:0] rd_val;
  logic [23:0]              offs;
  logic                     ready_q;
  logic                     acc;
  logic                     wr;

  assign offs   = addr_i.fld.offset;
  assign acc    = valid_i & ~ready_q;
  assign wr     = acc & (|wstrb_i);
  assign wr_val = wdata_i[`RETRO_GPIO_W-1:0];
  assign rise   = sync2_q & ~prev_q;
  // write-one-to-clear on the status register
  assign stat_clr = (wr && offs == `GPIO_IRQ_STAT) ? wr_val : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q    <= 1'b0;
      out_q      <= '0;
      oen_q      <= '1;
      pun_q      <= '0;
      pdn_q      <= '0;
      irq_en_q   <= '0;
      irq_stat_q <= '0;
      sync1_q    <= '0;
      sync2_q    <= '0;
      prev_q     <= '0;
    end else begin
      ready_q <= acc;
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // a new edge wins over a clear in the same cycle
      irq_stat_q <= (irq_stat_q & ~stat_clr) | rise;
      if (wr) begin
        case (offs)
          `GPIO_OUT:    out_q    <= wr_val;
          `GPIO_OEN:    oen_q    <= wr_val;
          `GPIO_PUN:    pun_q    <= wr_val;
          `GPIO_PDN:    pdn_q    <= wr_val;
          `GPIO_IRQ_EN: irq_en_q <= wr_val;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offs)
      `GPIO_OUT:      rd_val = out_q;
      `GPIO_IN:       rd_val = sync2_q;
      `GPIO_OEN:      rd_val = oen_q;
      `GPIO_PUN:      rd_val = pun_q;
      `GPIO_PDN:      rd_val = pdn_q;
      `GPIO_IRQ_EN:   rd_val = irq_en_q;
      `GPIO_IRQ_STAT: rd_val = irq_stat_q;
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_o <= {{(32-`RETRO_GPIO_W){1'b0}}, rd_val};
    end
  end

  assign ready_o    = ready_q;
  assign gpio_out_o = out_q;
  assign gpio_oen_o = oen_q;
  assign gpio_pun_o = pun_q;
  assign gpio_pdn_o = pdn_q;
  assign irq_o      = |(irq_stat_q & irq_en_q);

endmodule

//--- natv_timer.sv
// counts 0..cmp and wraps; a count written above cmp runs on until the 32-bit wrap
`timescale 1ns/10ps
`include "retrosoc_settings.svh"

module natv_timer (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  retrosoc_pkg::nmi_addr_u addr_i,
  input  logic [31:0]             wdata_i,
  input  logic [3:0]              wstrb_i,
  output logic                    ready_o,
  output logic [31:0]             rdata_o,
  output logic                    irq_o
);

  logic [31:0] cnt_q;
  logic [31:0] cmp_q;
  logic [1:0]  ctrl_q;
  logic        match_q;
  logic        ready_q;
  logic        acc;
  logic        wr;
  logic        hit;
  logic [23:0] offs;

  assign offs = addr_i.fld.offset;
  assign acc  = valid_i & ~ready_q;
  assign wr   = acc & (|wstrb_i);
  assign hit  = ctrl_q[0] & (cnt_q == cmp_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
      cnt_q   <= '0;
      cmp_q   <= '0;
      ctrl_q  <= '0;
      match_q <= 1'b0;
    end else begin
      ready_q <= acc;
      // bus write to the count overrides the increment
      if (wr && offs == `TMR_CNT) begin
        cnt_q <= wdata_i;
      end else if (hit) begin
        cnt_q <= '0;
      end else if (ctrl_q[0]) begin
        cnt_q <= cnt_q + 32'd1;
      end
      if (wr && offs == `TMR_CMP) begin
        cmp_q <= wdata_i;
      end
      if (wr && offs == `TMR_CTRL) begin
        ctrl_q <= wdata_i[1:0];
      end
      // sticky match, set beats clear
      if (hit) begin
        match_q <= 1'b1;
      end else if (wr && offs == `TMR_STAT && wdata_i[0]) begin
        match_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      case (offs)
        `TMR_CNT:  rdata_o <= cnt_q;
        `TMR_CMP:  rdata_o <= cmp_q;
        `TMR_CTRL: rdata_o <= {30'd0, ctrl_q};
        `TMR_STAT: rdata_o <= {31'd0, match_q};
        default:   rdata_o <= '0;
      endcase
    end
  end

  assign ready_o = ready_q;
  assign irq_o   = match_q & ctrl_q[1];

endmodule

//--- retrosoc_lite.sv
// cpu-less top, driven through the native port; irq_o bit 2 is a one-cycle pulse, bits 1:0 are levels
`timescale 1ns/10ps
`include "retrosoc_settings.svh"

module retrosoc_lite (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     mem_valid_i,
  input  logic [31:0]              mem_addr_i,
  input  logic [31:0]              mem_wdata_i,
  input  logic [3:0]               mem_wstrb_i,
  output logic [31:0]              mem_rdata_o,
  output logic                     mem_ready_o,
  input  logic [`RETRO_GPIO_W-1:0] gpio_in_i,
  output logic [`RETRO_GPIO_W-1:0] gpio_out_o,
  output logic [`RETRO_GPIO_W-1:0] gpio_oen_o,
  output logic [`RETRO_GPIO_W-1:0] gpio_pun_o,
  output logic [`RETRO_GPIO_W-1:0] gpio_pdn_o,
  output logic [2:0]               irq_o
);

  retrosoc_pkg::nmi_addr_u s_slv_addr;
  logic [31:0]             s_slv_wdata;
  logic [3:0]              s_slv_wstrb;
  logic                    s_sram_valid;
  logic                    s_sram_ready;
  logic [31:0]             s_sram_rdata;
  logic                    s_gpio_valid;
  logic                    s_gpio_ready;
  logic [31:0]             s_gpio_rdata;
  logic                    s_tmr_valid;
  logic                    s_tmr_ready;
  logic [31:0]             s_tmr_rdata;
  logic                    s_gpio_irq;
  logic                    s_tmr_irq;
  logic                    s_bus_err;

  nmi_bus u_bus (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o),
    .sram_valid_o(s_sram_valid),
    .sram_ready_i(s_sram_ready),
    .sram_rdata_i(s_sram_rdata),
    .gpio_valid_o(s_gpio_valid),
    .gpio_ready_i(s_gpio_ready),
    .gpio_rdata_i(s_gpio_rdata),
    .tmr_valid_o (s_tmr_valid),
    .tmr_ready_i (s_tmr_ready),
    .tmr_rdata_i (s_tmr_rdata),
    .slv_addr_o  (s_slv_addr),
    .slv_wdata_o (s_slv_wdata),
    .slv_wstrb_o (s_slv_wstrb),
    .bus_err_o   (s_bus_err)
  );

  nmi_sram u_sram (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (s_sram_valid),
    .addr_i  (s_slv_addr),
    .wdata_i (s_slv_wdata),
    .wstrb_i (s_slv_wstrb),
    .ready_o (s_sram_ready),
    .rdata_o (s_sram_rdata)
  );

  natv_gpio u_gpio (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (s_gpio_valid),
    .addr_i    (s_slv_addr),
    .wdata_i   (s_slv_wdata),
    .wstrb_i   (s_slv_wstrb),
    .ready_o   (s_gpio_ready),
    .rdata_o   (s_gpio_rdata),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oen_o(gpio_oen_o),
    .gpio_pun_o(gpio_pun_o),
    .gpio_pdn_o(gpio_pdn_o),
    .irq_o     (s_gpio_irq)
  );

  natv_timer u_timer (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (s_tmr_valid),
    .addr_i  (s_slv_addr),
    .wdata_i (s_slv_wdata),
    .wstrb_i (s_slv_wstrb),
    .ready_o (s_tmr_ready),
    .rdata_o (s_tmr_rdata),
    .irq_o   (s_tmr_irq)
  );

  // bus error rides along with the peripheral lines
  assign irq_o = {s_bus_err, s_tmr_irq, s_gpio_irq};

endmodule

//--- tb_retrosoc_lite.sv
// rdata is compared on reads only; sram data and addresses come from $urandom with a fixed seed
`timescale 1ns/10ps
`include "retrosoc_settings.svh"

module tb_retrosoc_lite;

  logic        clk_i;
  logic        arst_n_i;
  logic        mem_valid_i;
  logic [31:0] mem_addr_i;
  logic [31:0] mem_wdata_i;
  logic [3:0]  mem_wstrb_i;
  logic [31:0] mem_rdata_o;
  logic        mem_ready_o;
  logic [7:0]  gpio_in_i;
  logic [7:0]  gpio_out_o;
  logic [7:0]  gpio_oen_o;
  logic [7:0]  gpio_pun_o;
  logic [7:0]  gpio_pdn_o;
  logic [2:0]  irq_o;

  // one column per field, one row per access
  string       t_name[$];
  logic [3:0]  t_wstrb[$];
  logic [31:0] t_addr[$];
  logic [31:0] t_wdata[$];
  logic [31:0] t_rdata[$];
  logic [2:0]  t_irq[$];
  logic [7:0]  t_gpio[$];
  int          t_idle[$];

  int err_count   = 0;
  int bad_tests   = 0;
  int test_errs   = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 1000;

  retrosoc_lite uut (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .mem_valid_i(mem_valid_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .mem_rdata_o(mem_rdata_o),
    .mem_ready_o(mem_ready_o),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oen_o (gpio_oen_o),
    .gpio_pun_o (gpio_pun_o),
    .gpio_pdn_o (gpio_pdn_o),
    .irq_o      (irq_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic add_entry(input string name, input logic [3:0] strb, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata,
                           input logic [2:0] irq, input logic [7:0] gpio, input int idle);
    t_name.push_back(name);
    t_wstrb.push_back(strb);
    t_addr.push_back(addr);
    t_wdata.push_back(wdata);
    t_rdata.push_back(rdata);
    t_irq.push_back(irq);
    t_gpio.push_back(gpio);
    t_idle.push_back(idle);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    err_count++;
    test_errs++;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      report_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  // byte-lane merge of a strobed write over the old word
  function automatic logic [31:0] strobe_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] sram_addr(input logic [7:0] idx);
    return {`RETRO_REGION_SRAM, 14'd0, idx, 2'b00};
  endfunction

  // pin register that mirrors a gpio offset
  function automatic logic [31:0] gpio_port(input logic [23:0] offs);
    case (offs)
      `GPIO_OUT: return {24'd0, gpio_out_o};
      `GPIO_OEN: return {24'd0, gpio_oen_o};
      `GPIO_PUN: return {24'd0, gpio_pun_o};
      default:   return {24'd0, gpio_pdn_o};
    endcase
  endfunction

  // starts and ends 1 ns after a rising edge
  task automatic run_access(input int i);
    int waited;
    gpio_in_i = t_gpio[i];
    repeat (t_idle[i]) begin
      @(posedge clk_i);
      #1;
    end
    mem_valid_i = 1'b1;
    mem_addr_i  = t_addr[i];
    mem_wdata_i = t_wdata[i];
    mem_wstrb_i = t_wstrb[i];
    waited = 0;
    while (mem_ready_o !== 1'b1 && waited < 8) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (mem_ready_o !== 1'b1) begin
      report_error($sformatf("no ready for %s within %0d cycles", t_name[i], waited));
    end else begin
      if (waited != 1) begin
        report_error($sformatf("ready for %s came %0d cycles after valid instead of 1",
                               t_name[i], waited));
      end
      if (t_wstrb[i] == 4'd0) begin
        check_value(t_name[i], t_rdata[i], mem_rdata_o);
      end
      check_value({t_name[i], " irq"}, {29'd0, t_irq[i]}, {29'd0, irq_o});
      // reads of out, oen, pun and pdn must match the pins too
      if (t_wstrb[i] == 4'd0 && t_addr[i][31:24] == `RETRO_REGION_GPIO &&
          t_addr[i][23:0] != `GPIO_IN && t_addr[i][23:0] <= `GPIO_PDN) begin
        check_value({t_name[i], " pin"}, t_rdata[i], gpio_port(t_addr[i][23:0]));
      end
    end
    // valid held over the next edge to catch a repeated ready
    @(posedge clk_i);
    #1;
    if (mem_ready_o !== 1'b0 || irq_o[2] !== 1'b0) begin
      report_error($sformatf("ready or bus error still high the cycle after %s", t_name[i]));
    end
    mem_valid_i = 1'b0;
    mem_wstrb_i = 4'd0;
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  w0;
    logic [7:0]  w1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] d3;
    // seed once for the whole run
    r           = $urandom(32'h9025_8808);
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i  = 32'd0;
    mem_wdata_i = 32'd0;
    mem_wstrb_i = 4'd0;
    gpio_in_i   = 8'd0;
    r  = $urandom();
    w0 = r[7:0];
    w1 = w0 ^ 8'h80;
    d0 = $urandom();
    d1 = $urandom();
    d2 = $urandom();
    d3 = $urandom();

    add_entry("sram_wr0", 4'hF, sram_addr(w0), d0, 32'd0, 3'b000, 8'h00, 0);
    add_entry("sram_rd0", 4'h0, sram_addr(w0), 32'd0, d0, 3'b000, 8'h00, 0);
    add_entry("sram_wr1", 4'hF, sram_addr(w1), d1, 32'd0, 3'b000, 8'h00, 0);
    add_entry("sram_rd1", 4'h0, sram_addr(w1), 32'd0, d1, 3'b000, 8'h00, 1);
    add_entry("sram_part", 4'h5, sram_addr(w1), d2, 32'd0, 3'b000, 8'h00, 0);
    add_entry("sram_merge", 4'h0, sram_addr(w1), 32'd0, strobe_merge(d1, d2, 4'h5),
              3'b000, 8'h00, 0);
    add_entry("sram_hi", 4'h8, sram_addr(w0), d3, 32'd0, 3'b000, 8'h00, 0);
    add_entry("sram_hi_rd", 4'h0, sram_addr(w0), 32'd0, strobe_merge(d0, d3, 4'h8),
              3'b000, 8'h00, 0);
    add_entry("gpio_out_rst", 4'h0, {`RETRO_REGION_GPIO, `GPIO_OUT}, 32'd0, 32'h00,
              3'b000, 8'h00, 0);
    add_entry("gpio_oen_rst", 4'h0, {`RETRO_REGION_GPIO, `GPIO_OEN}, 32'd0, 32'hFF,
              3'b000, 8'h00, 0);
    add_entry("gpio_pun_rst", 4'h0, {`RETRO_REGION_GPIO, `GPIO_PUN}, 32'd0, 32'h00,
              3'b000, 8'h00, 0);
    add_entry("gpio_pdn_rst", 4'h0, {`RETRO_REGION_GPIO, `GPIO_PDN}, 32'd0, 32'h00,
              3'b000, 8'h00, 0);
    add_entry("gpio_out_wr", 4'hF, {`RETRO_REGION_GPIO, `GPIO_OUT}, 32'hA5, 32'd0,
              3'b000, 8'h00, 0);
    add_entry("gpio_out_rd", 4'h0, {`RETRO_REGION_GPIO, `GPIO_OUT}, 32'd0, 32'hA5,
              3'b000, 8'h00, 0);
    add_entry("gpio_oen_wr", 4'hF, {`RETRO_REGION_GPIO, `GPIO_OEN}, 32'h0F, 32'd0,
              3'b000, 8'h00, 0);
    add_entry("gpio_oen_rd", 4'h0, {`RETRO_REGION_GPIO, `GPIO_OEN}, 32'd0, 32'h0F,
              3'b000, 8'h00, 0);
    add_entry("gpio_pun_wr", 4'hF, {`RETRO_REGION_GPIO, `GPIO_PUN}, 32'h33, 32'd0,
              3'b000, 8'h00, 0);
    add_entry("gpio_pun_rd", 4'h0, {`RETRO_REGION_GPIO, `GPIO_PUN}, 32'd0, 32'h33,
              3'b000, 8'h00, 0);
    add_entry("gpio_pdn_wr", 4'hF, {`RETRO_REGION_GPIO, `GPIO_PDN}, 32'hCC, 32'd0,
              3'b000, 8'h00, 0);
    add_entry("gpio_pdn_rd", 4'h0, {`RETRO_REGION_GPIO, `GPIO_PDN}, 32'd0, 32'hCC,
              3'b000, 8'h00, 0);
    add_entry("gpio_irq_en", 4'hF, {`RETRO_REGION_GPIO, `GPIO_IRQ_EN}, 32'h01, 32'd0,
              3'b000, 8'h00, 0);
    // pin 0 rises, edge passes the synchronizer during the idle cycles
    add_entry("gpio_in_rd", 4'h0, {`RETRO_REGION_GPIO, `GPIO_IN}, 32'd0, 32'h01,
              3'b001, 8'h01, 5);
    add_entry("gpio_stat_rd", 4'h0, {`RETRO_REGION_GPIO, `GPIO_IRQ_STAT}, 32'd0, 32'h01,
              3'b001, 8'h01, 0);
    add_entry("gpio_stat_clr", 4'hF, {`RETRO_REGION_GPIO, `GPIO_IRQ_STAT}, 32'h01, 32'd0,
              3'b000, 8'h01, 0);
    add_entry("gpio_stat_rd2", 4'h0, {`RETRO_REGION_GPIO, `GPIO_IRQ_STAT}, 32'd0, 32'h00,
              3'b000, 8'h01, 0);
    add_entry("tmr_cmp_wr", 4'hF, {`RETRO_REGION_TIMER, `TMR_CMP}, 32'd10, 32'd0,
              3'b000, 8'h01, 0);
    add_entry("tmr_ctrl_wr", 4'hF, {`RETRO_REGION_TIMER, `TMR_CTRL}, 32'd3, 32'd0,
              3'b000, 8'h01, 0);
    add_entry("tmr_match_rd", 4'h0, {`RETRO_REGION_TIMER, `TMR_STAT}, 32'd0, 32'd1,
              3'b010, 8'h01, 16);
    // stop counting first so no new match races the clear
    add_entry("tmr_stop", 4'hF, {`RETRO_REGION_TIMER, `TMR_CTRL}, 32'd2, 32'd0,
              3'b010, 8'h01, 0);
    add_entry("tmr_stat_clr", 4'hF, {`RETRO_REGION_TIMER, `TMR_STAT}, 32'd1, 32'd0,
              3'b000, 8'h01, 0);
    add_entry("tmr_stat_rd", 4'h0, {`RETRO_REGION_TIMER, `TMR_STAT}, 32'd0, 32'd0,
              3'b000, 8'h01, 0);
    add_entry("tmr_cnt_wr", 4'hF, {`RETRO_REGION_TIMER, `TMR_CNT}, 32'h55, 32'd0,
              3'b000, 8'h01, 0);
    add_entry("tmr_cnt_rd", 4'h0, {`RETRO_REGION_TIMER, `TMR_CNT}, 32'd0, 32'h55,
              3'b000, 8'h01, 2);
    add_entry("unmapped_rd", 4'h0, {8'h7F, 24'h00_0000}, 32'd0, `RETRO_BUS_ERR_WORD,
              3'b100, 8'h01, 0);
    cycle_limit = t_name.size() * 20 + 300;

    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    foreach (t_name[i]) begin
      test_errs = 0;
      run_access(i);
      if (test_errs == 0) begin
        $display("test %s ok", t_name[i]);
      end else begin
        $display("test %s error", t_name[i]);
        bad_tests++;
      end
    end
    $display("summary: %0d tests, %0d bad tests, %0d errors", t_name.size(), bad_tests,
             err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- retrosoc_lite.f
+incdir+.
retrosoc_pkg.sv
nmi_bus.sv
nmi_sram.sv
natv_gpio.sv
natv_timer.sv
retrosoc_lite.sv
tb_retrosoc_lite.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing -f retrosoc_lite.f --top-module tb_retrosoc_lite -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || grep -q "ALL CHECKS PASSED" sim.log \
  || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
